// File: design/tcp_tx_consts.svh
`ifndef TCP_TX_CONSTS_SVH
`define TCP_TX_CONSTS_SVH

// Header geometry, IPv4 plus TCP without options.
`define TCP_HDR_BYTES 16'd40
`define TCP_HDR_WORDS 10

// TCP flag bits.
`define TCP_FLAG_FIN 8'h01
`define TCP_FLAG_SYN 8'h02
`define TCP_FLAG_RST 8'h04
`define TCP_FLAG_PSH 8'h08
`define TCP_FLAG_ACK 8'h10
`define TCP_FLAG_URG 8'h20
`define TCP_FLAG_ECE 8'h40
`define TCP_FLAG_CWR 8'h80

// Advertised receive window.
`define TCP_WINDOW 16'h100

// IPv4 fixed fields.
`define IP_TTL 8'd64
`define IP_PROTO_TCP 8'd6
`define IP_FLAGS_DF 16'h4000

`endif

// File: design/tcp_pkg.sv
`default_nettype none

package tcp_pkg;

    // Segment commands from the connection logic.
    typedef enum logic [1:0] {
        TX_CTRL_SEND_SYN,
        TX_CTRL_SEND_ACK,
        TX_CTRL_SEND_FIN
    } tx_ctrl_t;

    typedef logic [31:0] seq_num_t;

    // IP total length or payload byte count.
    typedef logic [15:0] ip_len_t;

    typedef logic [7:0]  tcp_flags_t;
    typedef logic [15:0] window_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] tcp_port_t;

    // One beat of the 32-bit streams.
    typedef logic [31:0] word_t;

endpackage

`default_nettype wire

// File: design/tcp_tx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "tcp_tx_consts.svh"

module tcp_tx_ctrl (
    input  wire                         i_clk,
    input  wire                         i_rst,

    input  wire tcp_pkg::tx_ctrl_t      i_tx_ctrl,
    input  wire                         i_tx_ctrl_valid,
    output logic                        o_tx_ctrl_ack,

    input  wire tcp_pkg::word_t         i_s_tdata,
    input  wire                         i_s_tvalid,
    input  wire                         i_s_tlast,
    output logic                        o_s_tready,
    input  wire tcp_pkg::ip_len_t       i_s_len,

    output tcp_pkg::word_t              o_m_tdata,
    output logic                        o_m_tvalid,
    output logic                        o_m_tlast,
    input  wire                         i_m_tready,

    output logic                        o_no_data,
    output tcp_pkg::ip_len_t            o_ip_len,
    output tcp_pkg::seq_num_t           o_seq_number,
    output tcp_pkg::seq_num_t           o_ack_number,
    output tcp_pkg::tcp_flags_t         o_flags,
    output tcp_pkg::window_t            o_window_size,
    output logic                        o_hdr_valid,

    input  wire                         i_packet_done
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_SYN,
        SEND_ACK,
        SEND_FIN,
        SEND_DATA
    } state_t;

    state_t             state_q;
    state_t             state_d;
    tcp_pkg::seq_num_t  seq_q;
    tcp_pkg::seq_num_t  seq_d;
    logic               data_phase;

    assign data_phase = (state_q == SEND_DATA);

    // ~~~~~~~~~~~~~~~~~~~~
    // Payload pass-through, open only during a data segment.
    assign o_m_tdata  = i_s_tdata;
    assign o_m_tvalid = i_s_tvalid && data_phase;
    assign o_m_tlast  = i_s_tlast;
    assign o_s_tready = i_m_tready && data_phase;

    assign o_seq_number  = seq_q;
    assign o_ack_number  = '0;
    assign o_window_size = `TCP_WINDOW;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= IDLE;
            seq_q   <= '0;
        end else begin
            state_q <= state_d;
            seq_q   <= seq_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Segment selection and sequence advance.
    always_comb begin
        state_d       = state_q;
        seq_d         = seq_q;
        o_tx_ctrl_ack = 1'b0;
        o_no_data     = 1'b1;
        o_flags       = '0;
        o_ip_len      = `TCP_HDR_BYTES;
        o_hdr_valid   = 1'b0;

        case (state_q)
            IDLE: begin
                // Waiting payload wins over a command.
                if (i_s_tvalid) begin
                    state_d = SEND_DATA;
                end else if (i_tx_ctrl_valid) begin
                    o_tx_ctrl_ack = 1'b1;
                    case (i_tx_ctrl)
                        tcp_pkg::TX_CTRL_SEND_SYN: state_d = SEND_SYN;
                        tcp_pkg::TX_CTRL_SEND_ACK: state_d = SEND_ACK;
                        tcp_pkg::TX_CTRL_SEND_FIN: state_d = SEND_FIN;
                        default: begin
                            state_d       = IDLE;
                            o_tx_ctrl_ack = 1'b0;
                        end
                    endcase
                end
            end

            SEND_SYN: begin
                o_flags     = `TCP_FLAG_SYN;
                o_hdr_valid = 1'b1;
                if (i_packet_done) begin
                    state_d = IDLE;
                    seq_d   = seq_q + 32'd1;
                end
            end

            SEND_ACK: begin
                o_flags     = `TCP_FLAG_ACK;
                o_hdr_valid = 1'b1;
                if (i_packet_done) begin
                    state_d = IDLE;
                end
            end

            SEND_FIN: begin
                o_flags     = `TCP_FLAG_ACK | `TCP_FLAG_FIN;
                o_hdr_valid = 1'b1;
                // FIN takes one sequence number.
                if (i_packet_done) begin
                    state_d = IDLE;
                    seq_d   = seq_q + 32'd1;
                end
            end

            SEND_DATA: begin
                o_flags     = `TCP_FLAG_ACK | `TCP_FLAG_PSH;
                o_no_data   = 1'b0;
                o_ip_len    = `TCP_HDR_BYTES + i_s_len;
                o_hdr_valid = 1'b1;
                if (i_packet_done) begin
                    state_d = IDLE;
                    seq_d   = seq_q + {16'd0, i_s_len};
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/tcp_hdr_serializer.sv
`timescale 1ns/100ps
`default_nettype none

`include "tcp_tx_consts.svh"

module tcp_hdr_serializer (
    input  wire                         i_clk,
    input  wire                         i_rst,

    input  wire                         i_no_data,
    input  wire tcp_pkg::ip_len_t       i_ip_len,
    input  wire tcp_pkg::seq_num_t      i_seq_number,
    input  wire tcp_pkg::seq_num_t      i_ack_number,
    input  wire tcp_pkg::tcp_flags_t    i_flags,
    input  wire tcp_pkg::window_t       i_window_size,
    input  wire                         i_hdr_valid,

    input  wire tcp_pkg::ip_addr_t      i_src_ip,
    input  wire tcp_pkg::ip_addr_t      i_dst_ip,
    input  wire tcp_pkg::tcp_port_t     i_src_port,
    input  wire tcp_pkg::tcp_port_t     i_dst_port,

    input  wire tcp_pkg::word_t         i_p_tdata,
    input  wire                         i_p_tvalid,
    input  wire                         i_p_tlast,
    output logic                        o_p_tready,

    output tcp_pkg::word_t              o_m_tdata,
    output logic                        o_m_tvalid,
    output logic                        o_m_tlast,
    input  wire                         i_m_tready,

    output logic                        o_packet_done
);

    typedef enum logic [2:0] {
        IDLE,
        SUM,
        FOLD,
        HDR,
        PAYLOAD
    } state_t;

    localparam logic [3:0] LAST_HDR_WORD = 4'(`TCP_HDR_WORDS - 1);
    // Words 0 to 4 form the IPv4 header.
    localparam logic [3:0] LAST_IP_WORD  = 4'd4;

    state_t                 state_q;
    logic [3:0]             cnt_q;
    logic                   latch;

    logic                   no_data_q;
    tcp_pkg::ip_len_t       ip_len_q;
    tcp_pkg::seq_num_t      seq_q;
    tcp_pkg::seq_num_t      ack_q;
    tcp_pkg::tcp_flags_t    flags_q;
    tcp_pkg::window_t       window_q;
    tcp_pkg::ip_addr_t      src_ip_q;
    tcp_pkg::ip_addr_t      dst_ip_q;
    tcp_pkg::tcp_port_t     src_port_q;
    tcp_pkg::tcp_port_t     dst_port_q;

    logic [19:0]            acc_q;
    logic [15:0]            csum_q;
    logic [19:0]            half_sum;
    logic [16:0]            fold1;
    logic [15:0]            fold2;

    tcp_pkg::word_t         hdr_word;
    logic                   hdr_beat;
    logic                   hdr_last;

    assign latch = (state_q == IDLE) && i_hdr_valid;

    // ~~~~~~~~~~~~~~~~~~~~
    // Header word select, also feeds the checksum sum.
    always_comb begin
        case (cnt_q)
            4'd0:    hdr_word = {8'h45, 8'h00, ip_len_q};
            4'd1:    hdr_word = {16'h0000, `IP_FLAGS_DF};
            4'd2:    hdr_word = {`IP_TTL, `IP_PROTO_TCP, csum_q};
            4'd3:    hdr_word = src_ip_q;
            4'd4:    hdr_word = dst_ip_q;
            4'd5:    hdr_word = {src_port_q, dst_port_q};
            4'd6:    hdr_word = seq_q;
            4'd7:    hdr_word = ack_q;
            4'd8:    hdr_word = {8'h50, flags_q, window_q};
            default: hdr_word = '0;
        endcase
    end

    assign half_sum = {4'd0, hdr_word[31:16]} + {4'd0, hdr_word[15:0]};

    // Two folds cover any carry out of twenty bits.
    assign fold1 = {1'b0, acc_q[15:0]} + {13'd0, acc_q[19:16]};
    assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

    // ~~~~~~~~~~~~~~~~~~~~
    // Field latch and checksum datapath.
    always_ff @(posedge i_clk) begin
        if (latch) begin
            no_data_q  <= i_no_data;
            ip_len_q   <= i_ip_len;
            seq_q      <= i_seq_number;
            ack_q      <= i_ack_number;
            flags_q    <= i_flags;
            window_q   <= i_window_size;
            src_ip_q   <= i_src_ip;
            dst_ip_q   <= i_dst_ip;
            src_port_q <= i_src_port;
            dst_port_q <= i_dst_port;
            acc_q      <= '0;
            csum_q     <= '0;
        end
        if (state_q == SUM) begin
            acc_q <= acc_q + half_sum;
        end
        if (state_q == FOLD) begin
            csum_q <= ~fold2;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequencing.
    assign hdr_beat = (state_q == HDR) && i_m_tready;
    assign hdr_last = no_data_q && (cnt_q == LAST_HDR_WORD);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (latch) begin
                        state_q <= SUM;
                    end
                end
                SUM: begin
                    if (cnt_q == LAST_IP_WORD) begin
                        cnt_q   <= '0;
                        state_q <= FOLD;
                    end else begin
                        cnt_q <= cnt_q + 4'd1;
                    end
                end
                FOLD: begin
                    state_q <= HDR;
                end
                HDR: begin
                    if (hdr_beat) begin
                        if (cnt_q == LAST_HDR_WORD) begin
                            cnt_q   <= '0;
                            state_q <= no_data_q ? IDLE : PAYLOAD;
                        end else begin
                            cnt_q <= cnt_q + 4'd1;
                        end
                    end
                end
                PAYLOAD: begin
                    if (o_packet_done) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Output mux.
    always_comb begin
        o_m_tdata     = hdr_word;
        o_m_tvalid    = 1'b0;
        o_m_tlast     = 1'b0;
        o_p_tready    = 1'b0;
        o_packet_done = 1'b0;
        case (state_q)
            HDR: begin
                o_m_tvalid    = 1'b1;
                o_m_tlast     = hdr_last;
                o_packet_done = hdr_last && i_m_tready;
            end
            PAYLOAD: begin
                o_m_tdata     = i_p_tdata;
                o_m_tvalid    = i_p_tvalid;
                o_m_tlast     = i_p_tlast;
                o_p_tready    = i_m_tready;
                o_packet_done = i_p_tvalid && i_p_tlast && i_m_tready;
            end
            default: begin
                o_m_tvalid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/tcp_tx.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_tx (
    input  wire                         i_clk,
    input  wire                         i_rst,

    input  wire tcp_pkg::tx_ctrl_t      i_tx_ctrl,
    input  wire                         i_tx_ctrl_valid,
    output logic                        o_tx_ctrl_ack,

    input  wire tcp_pkg::word_t         i_s_tdata,
    input  wire                         i_s_tvalid,
    input  wire                         i_s_tlast,
    output logic                        o_s_tready,
    input  wire tcp_pkg::ip_len_t       i_s_len,

    input  wire tcp_pkg::ip_addr_t      i_src_ip,
    input  wire tcp_pkg::ip_addr_t      i_dst_ip,
    input  wire tcp_pkg::tcp_port_t     i_src_port,
    input  wire tcp_pkg::tcp_port_t     i_dst_port,

    output tcp_pkg::word_t              o_m_tdata,
    output logic                        o_m_tvalid,
    output logic                        o_m_tlast,
    input  wire                         i_m_tready
);

    // Header fields, controller to serializer.
    logic                   no_data;
    tcp_pkg::ip_len_t       ip_len;
    tcp_pkg::seq_num_t      seq_number;
    tcp_pkg::seq_num_t      ack_number;
    tcp_pkg::tcp_flags_t    flags;
    tcp_pkg::window_t       window_size;
    logic                   hdr_valid;
    logic                   packet_done;

    // Payload stream between the blocks.
    tcp_pkg::word_t         p_tdata;
    logic                   p_tvalid;
    logic                   p_tlast;
    logic                   p_tready;

    tcp_tx_ctrl ctrl_i (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_tx_ctrl       (i_tx_ctrl),
        .i_tx_ctrl_valid (i_tx_ctrl_valid),
        .o_tx_ctrl_ack   (o_tx_ctrl_ack),
        .i_s_tdata       (i_s_tdata),
        .i_s_tvalid      (i_s_tvalid),
        .i_s_tlast       (i_s_tlast),
        .o_s_tready      (o_s_tready),
        .i_s_len         (i_s_len),
        .o_m_tdata       (p_tdata),
        .o_m_tvalid      (p_tvalid),
        .o_m_tlast       (p_tlast),
        .i_m_tready      (p_tready),
        .o_no_data       (no_data),
        .o_ip_len        (ip_len),
        .o_seq_number    (seq_number),
        .o_ack_number    (ack_number),
        .o_flags         (flags),
        .o_window_size   (window_size),
        .o_hdr_valid     (hdr_valid),
        .i_packet_done   (packet_done)
    );

    tcp_hdr_serializer ser_i (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_no_data       (no_data),
        .i_ip_len        (ip_len),
        .i_seq_number    (seq_number),
        .i_ack_number    (ack_number),
        .i_flags         (flags),
        .i_window_size   (window_size),
        .i_hdr_valid     (hdr_valid),
        .i_src_ip        (i_src_ip),
        .i_dst_ip        (i_dst_ip),
        .i_src_port      (i_src_port),
        .i_dst_port      (i_dst_port),
        .i_p_tdata       (p_tdata),
        .i_p_tvalid      (p_tvalid),
        .i_p_tlast       (p_tlast),
        .o_p_tready      (p_tready),
        .o_m_tdata       (o_m_tdata),
        .o_m_tvalid      (o_m_tvalid),
        .o_m_tlast       (o_m_tlast),
        .i_m_tready      (i_m_tready),
        .o_packet_done   (packet_done)
    );

endmodule

`default_nettype wire

// File: tests/tcp_tx_properties.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_tx_properties (
    input  wire         i_clk,
    input  wire         i_rst,
    input  wire [31:0]  i_m_tdata,
    input  wire         i_m_tvalid,
    input  wire         i_m_tlast,
    input  wire         i_m_tready,
    input  wire         i_tx_ctrl_ack,
    input  wire         i_s_tready
);

    logic [3:0] hdr_seen;
    logic       beat;
    int         fail_count = 0;

    assign beat = i_m_tvalid && i_m_tready;

    // Header beats of the current packet, saturating at ten.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hdr_seen <= '0;
        end else if (beat && i_m_tlast) begin
            hdr_seen <= '0;
        end else if (beat && hdr_seen != 4'd10) begin
            hdr_seen <= hdr_seen + 4'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_m_tvalid && !i_m_tready |=> i_m_tvalid && $stable(i_m_tdata) && $stable(i_m_tlast))
        else begin
            $error("output beat changed while stalled");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge i_clk)
        i_rst && $past(i_rst) |-> !i_m_tvalid && !i_tx_ctrl_ack && !i_s_tready)
        else begin
            $error("activity on outputs during reset");
            fail_count++;
        end

    ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tx_ctrl_ack |=> !i_tx_ctrl_ack)
        else begin
            $error("command acknowledge held longer than one cycle");
            fail_count++;
        end

    ready_after_hdr: assert property (@(posedge i_clk) disable iff (i_rst)
        i_s_tready |-> hdr_seen == 4'd10)
        else begin
            $error("payload ready raised before the header was sent");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tests/tcp_tx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_tx_tb;

    localparam logic [31:0] SRC_IP   = 32'hc0a8_0001;
    localparam logic [31:0] DST_IP   = 32'hc0a8_0002;
    localparam logic [15:0] SRC_PORT = 16'h1f90;
    localparam logic [15:0] DST_PORT = 16'hc350;

    localparam logic [1:0] K_SYN  = 2'd0;
    localparam logic [1:0] K_ACK  = 2'd1;
    localparam logic [1:0] K_FIN  = 2'd2;
    localparam logic [1:0] K_DATA = 2'd3;
    localparam int ROWS = 10;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus table. Overlap rows are raised together with the payload above them.
    logic [1:0] tbl_kind [ROWS] = '{K_SYN, K_ACK, K_DATA, K_DATA, K_ACK,
                                    K_DATA, K_ACK, K_DATA, K_FIN, K_ACK};
    int         tbl_words [ROWS] = '{0, 0, 4, 1, 0, 6, 0, 3, 0, 0};
    logic [7:0] tbl_flags [ROWS] = '{8'h02, 8'h10, 8'h18, 8'h18, 8'h10,
                                     8'h18, 8'h10, 8'h18, 8'h11, 8'h10};
    bit         tbl_overlap [ROWS] = '{0, 0, 0, 0, 1, 0, 0, 0, 1, 0};
    bit         tbl_stall [ROWS] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1};

    logic               i_clk;
    logic               i_rst;
    tcp_pkg::tx_ctrl_t  i_tx_ctrl;
    logic               i_tx_ctrl_valid;
    logic               o_tx_ctrl_ack;
    logic [31:0]        i_s_tdata;
    logic               i_s_tvalid;
    logic               i_s_tlast;
    logic               o_s_tready;
    logic [15:0]        i_s_len;
    logic [31:0]        o_m_tdata;
    logic               o_m_tvalid;
    logic               o_m_tlast;
    logic               i_m_tready;

    logic [31:0]        lfsr_q = 32'hd5d3_5786;
    logic [31:0]        pay_mem [0:63];
    logic [31:0]        exp_data [$];
    logic               exp_last [$];
    logic [31:0]        exp_word;
    logic               exp_tlast;
    logic [31:0]        seq_exp;
    int                 pay_next;
    int                 ack_count;
    bit                 stall_on;
    bit                 payload_busy;

    tcp_tx dut_i (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_tx_ctrl       (i_tx_ctrl),
        .i_tx_ctrl_valid (i_tx_ctrl_valid),
        .o_tx_ctrl_ack   (o_tx_ctrl_ack),
        .i_s_tdata       (i_s_tdata),
        .i_s_tvalid      (i_s_tvalid),
        .i_s_tlast       (i_s_tlast),
        .o_s_tready      (o_s_tready),
        .i_s_len         (i_s_len),
        .i_src_ip        (SRC_IP),
        .i_dst_ip        (DST_IP),
        .i_src_port      (SRC_PORT),
        .i_dst_port      (DST_PORT),
        .o_m_tdata       (o_m_tdata),
        .o_m_tvalid      (o_m_tvalid),
        .o_m_tlast       (o_m_tlast),
        .i_m_tready      (i_m_tready)
    );

    bind tcp_tx tcp_tx_properties props_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_m_tdata     (o_m_tdata),
        .i_m_tvalid    (o_m_tvalid),
        .i_m_tlast     (o_m_tlast),
        .i_m_tready    (i_m_tready),
        .i_tx_ctrl_ack (o_tx_ctrl_ack),
        .i_s_tready    (o_s_tready)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits   = {bits[30:0], lfsr_q[31]};
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        end
        return bits;
    endfunction

    function automatic logic [15:0] ip_checksum(input logic [31:0] a, b, c, d, e);
        logic [31:0] words [0:4];
        logic [31:0] sum;
        words = '{a, b, c, d, e};
        sum = '0;
        for (int k = 0; k < 5; k++) begin
            sum = sum + words[k][31:16] + words[k][15:0];
        end
        while (sum[31:16] != 16'd0) begin
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    task automatic expect_header(input logic [7:0] flags, input logic [15:0] len,
                                 input logic [31:0] seq, input logic no_data);
        logic [31:0] w [0:9];
        w[0] = {8'h45, 8'h00, len};
        w[1] = 32'h0000_4000;
        w[2] = {8'd64, 8'd6, 16'h0000};
        w[3] = SRC_IP;
        w[4] = DST_IP;
        w[2][15:0] = ip_checksum(w[0], w[1], w[2], w[3], w[4]);
        w[5] = {SRC_PORT, DST_PORT};
        w[6] = seq;
        w[7] = 32'h0;
        w[8] = {8'h50, flags, 16'h0100};
        w[9] = 32'h0;
        for (int k = 0; k < 10; k++) begin
            exp_data.push_back(w[k]);
            exp_last.push_back(no_data && k == 9);
        end
    endtask

    task automatic expect_row(input int r);
        logic [15:0] len;
        len = 16'(tbl_words[r] * 4);
        expect_header(tbl_flags[r], 16'd40 + len, seq_exp, tbl_kind[r] != K_DATA);
        for (int k = 0; k < tbl_words[r]; k++) begin
            exp_data.push_back(pay_mem[pay_next + k]);
            exp_last.push_back(k == tbl_words[r] - 1);
        end
        pay_next += tbl_words[r];
        if (tbl_kind[r] == K_DATA) begin
            seq_exp += {16'd0, len};
        end else if (tbl_kind[r] != K_ACK) begin
            seq_exp += 32'd1;
        end
    endtask

    task automatic send_cmd(input logic [1:0] kind);
        @(negedge i_clk);
        i_tx_ctrl       = tcp_pkg::tx_ctrl_t'(kind);
        i_tx_ctrl_valid = 1'b1;
        do @(posedge i_clk); while (!o_tx_ctrl_ack);
        assert (!payload_busy) else begin
            $display("command was acknowledged while payload was still waiting");
            abort_run();
        end
        @(negedge i_clk);
        i_tx_ctrl_valid = 1'b0;
    endtask

    task automatic send_payload(input int base, input int n);
        payload_busy = 1'b1;
        for (int k = 0; k < n; k++) begin
            @(negedge i_clk);
            i_s_tvalid = 1'b1;
            i_s_tdata  = pay_mem[base + k];
            i_s_tlast  = (k == n - 1);
            i_s_len    = 16'(n * 4);
            do @(posedge i_clk); while (!o_s_tready);
        end
        payload_busy = 1'b0;
        @(negedge i_clk);
        i_s_tvalid = 1'b0;
        i_s_tlast  = 1'b0;
    endtask

    function automatic int total_beats();
        int n;
        n = 0;
        for (int r = 0; r < ROWS; r++) begin
            n += 10 + tbl_words[r];
        end
        return n;
    endfunction

    function automatic int cmd_rows();
        int n;
        n = 0;
        for (int r = 0; r < ROWS; r++) begin
            n += (tbl_kind[r] != K_DATA);
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Output ready, random only on rows marked for stalls.
    initial begin : ready_gen
        logic [31:0] bits;
        i_m_tready = 1'b1;
        forever begin
            @(negedge i_clk);
            if (stall_on) begin
                bits       = next_bits(1);
                i_m_tready = bits[0];
            end else begin
                i_m_tready = 1'b1;
            end
        end
    end

    always @(posedge i_clk) begin
        assert (dut_i.props_i.fail_count == 0) else begin
            $display("a bound assertion on the DUT ports failed");
            abort_run();
        end
        if (!i_rst) begin
            if (o_tx_ctrl_ack) begin
                ack_count++;
            end
            if (o_m_tvalid && i_m_tready) begin
                assert (exp_data.size() > 0) else begin
                    $display("an output beat arrived when no packet was expected");
                    abort_run();
                end
                exp_word  = exp_data.pop_front();
                exp_tlast = exp_last.pop_front();
                assert (o_m_tdata === exp_word) else begin
                    $display("ERR o_m_tdata got %h expected %h", o_m_tdata, exp_word);
                    abort_run();
                end
                assert (o_m_tlast === exp_tlast) else begin
                    $display("ERR o_m_tlast got %h expected %h", o_m_tlast, exp_tlast);
                    abort_run();
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = total_beats() * 20 + 200;
        repeat (limit) @(posedge i_clk);
        $display("watchdog expired after %0d cycles without the run finishing", limit);
        abort_run();
    end

    initial begin : main
        int idx;
        int base;
        int n;
        i_rst           = 1'b1;
        i_tx_ctrl       = tcp_pkg::TX_CTRL_SEND_SYN;
        i_tx_ctrl_valid = 1'b0;
        i_s_tdata       = '0;
        i_s_tvalid      = 1'b0;
        i_s_tlast       = 1'b0;
        i_s_len         = '0;
        seq_exp         = '0;
        pay_next        = 0;
        ack_count       = 0;
        stall_on        = 1'b0;
        payload_busy    = 1'b0;

        // Payload words for every data row, drawn before the ready pattern.
        n = 0;
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < tbl_words[r]; k++) begin
                pay_mem[n] = next_bits(32);
                n++;
            end
        end

        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        idx = 0;
        while (idx < ROWS) begin
            @(posedge i_clk);
            stall_on = tbl_stall[idx];
            base     = pay_next;
            expect_row(idx);
            if (tbl_kind[idx] != K_DATA) begin
                send_cmd(tbl_kind[idx]);
                idx += 1;
            end else if (idx + 1 < ROWS && tbl_overlap[idx + 1]) begin
                expect_row(idx + 1);
                fork
                    send_payload(base, tbl_words[idx]);
                    send_cmd(tbl_kind[idx + 1]);
                join
                idx += 2;
            end else begin
                send_payload(base, tbl_words[idx]);
                idx += 1;
            end
        end

        while (exp_data.size() != 0) @(posedge i_clk);
        repeat (4) @(posedge i_clk);
        assert (ack_count == cmd_rows()) else begin
            $display("ERR o_tx_ctrl_ack pulses got %h expected %h", ack_count, cmd_rows());
            abort_run();
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/tcp_pkg.sv
design/tcp_tx_ctrl.sv
design/tcp_hdr_serializer.sv
design/tcp_tx.sv
tests/tcp_tx_properties.sv
tests/tcp_tx_tb.sv

// File: Bender.yml
package:
  name: tcp_tx

sources:
  - include_dirs:
      - design
    files:
      - design/tcp_pkg.sv
      - design/tcp_tx_ctrl.sv
      - design/tcp_hdr_serializer.sv
      - design/tcp_tx.sv
  - target: test
    files:
      - tests/tcp_tx_properties.sv
      - tests/tcp_tx_tb.sv
